/* files.f */
verilog/rv_pkg.sv
verilog/inst_mem.sv
verilog/data_mem.sv
verilog/reg_file.sv
verilog/alu.sv
verilog/fetch_stage.sv
verilog/execute_stage.sv
verilog/writeback_stage.sv
verilog/rv_core_top.sv
sim/tb_rv_core.sv

/* sim/core_stim.txt */
// Word 0: program length. Then one instruction word per line, from RESET_PC up.
// Then retire records as <rd> <value>, in retire order; a lone 00 ends the list.
21
00500093 // 00 addi x1, x0, 5
FFD08113 // 04 addi x2, x1, -3
002081B3 // 08 add  x3, x1, x2
40310233 // 0c sub  x4, x2, x3
002192B3 // 10 sll  x5, x3, x2
40125313 // 14 srai x6, x4, 1
002253B3 // 18 srl  x7, x4, x2
00122433 // 1c slt  x8, x4, x1
001234B3 // 20 sltu x9, x4, x1
0051C533 // 24 xor  x10, x3, x5
005165B3 // 28 or   x11, x2, x5
0061F633 // 2c and  x12, x3, x6
123456B7 // 30 lui  x13, 0x12345
00D02423 // 34 sw   x13, 8(x0)
00802703 // 38 lw   x14, 8(x0)
00170793 // 3c addi x15, x14, 1
00208463 // 40 beq  x1, x2, +8    not taken
00209463 // 44 bne  x1, x2, +8    taken
06300813 // 48 addi x16, x0, 99   skipped
00124463 // 4c blt  x4, x1, +8    taken
06200813 // 50 addi x16, x0, 98   skipped
00125463 // 54 bge  x4, x1, +8    not taken
0040F463 // 58 bgeu x1, x4, +8    not taken
00700813 // 5c addi x16, x0, 7
0040E463 // 60 bltu x1, x4, +8    taken
06100813 // 64 addi x16, x0, 97   skipped
008008EF // 68 jal  x17, +8
06000813 // 6c addi x16, x0, 96   skipped
00000917 // 70 auipc x18, 0
00C909E7 // 74 jalr x19, 12(x18)
05F00813 // 78 addi x16, x0, 95   skipped
00498A13 // 7c addi x20, x19, 4
0000006F // 80 jal  x0, 0         park
01 00000005
02 00000002
03 00000007
04 FFFFFFFB
05 0000001C
06 FFFFFFFD
07 3FFFFFFE
08 00000001
09 00000000
0A 0000001B
0B 0000001E
0C 00000005
0D 12345000
0E 12345000
0F 12345001
10 00000007
11 0000006C
12 00000070
13 00000078
14 0000007C
00

/* sim/tb_rv_core.sv */
`timescale 1ns/1ps

module tb_rv_core;
    import rv_pkg::*;

    localparam xlen_t RESET_PC        = 32'h0000_0000;
    localparam int    IMEM_DEPTH_LOG2 = 10;
    localparam int    DMEM_DEPTH_LOG2 = 10;
    localparam int    RESET_CYCLES    = 5;
    localparam int    STIM_DEPTH      = 256;

    logic                       clk;
    logic                       rst;
    logic                       prog_we;
    logic [IMEM_DEPTH_LOG2-1:0] prog_addr;
    xlen_t                      prog_data;
    logic                       retire_valid;
    reg_addr_t                  retire_rd;
    xlen_t                      retire_data;

    logic [31:0] stim [STIM_DEPTH];
    int          prog_words;
    int          rec_idx;
    int          rec_num;
    int          cycle_count;
    int          cycle_limit;
    logic        running;

    rv_core_top #(
        .RESET_PC        (RESET_PC),
        .IMEM_DEPTH_LOG2 (IMEM_DEPTH_LOG2),
        .DMEM_DEPTH_LOG2 (DMEM_DEPTH_LOG2)
    ) uut (
        .clk          (clk),
        .rst          (rst),
        .prog_we      (prog_we),
        .prog_addr    (prog_addr),
        .prog_data    (prog_data),
        .retire_valid (retire_valid),
        .retire_rd    (retire_rd),
        .retire_data  (retire_data)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic check_equal(input string name, input xlen_t expected, input xlen_t actual);
        if (actual !== expected) begin
            $display("Error %s: expected %h, actual %h", name, expected, actual);
            $display("Simulation finished: FAIL");
            $fatal(1, "value mismatch");
        end
    endtask

    // Retire outputs are settled by the falling edge
    task automatic wait_for_retire();
        do begin
            @(negedge clk);
        end while (retire_valid !== 1'b1);
    endtask

    // Cycle limit, armed once the core leaves reset
    initial begin
        cycle_count = 0;
        wait (running === 1'b1);
        forever begin
            @(posedge clk);
            cycle_count++;
            if (cycle_count >= cycle_limit) begin
                $display("Timeout: expected retire records did not all arrive in %0d cycles",
                         cycle_count);
                $display("Simulation finished: FAIL");
                $fatal(1, "timeout");
            end
        end
    end

    initial begin
        rst         = 1'b1;
        prog_we     = 1'b0;
        prog_addr   = '0;
        prog_data   = '0;
        running     = 1'b0;
        cycle_limit = 0;
        rec_num     = 0;
        $readmemh("sim/core_stim.txt", stim);
        prog_words = stim[0];
        if (prog_words <= 0 || prog_words >= STIM_DEPTH - 1) begin
            $display("Stimulus file holds no usable program length");
            $display("Simulation finished: FAIL");
            $fatal(1, "bad stimulus");
        end

        // Program load through the write port, core held in reset
        for (int i = 0; i < prog_words; i++) begin
            @(posedge clk);
            #1;
            check_equal("retire_valid low in reset", 32'd0, retire_valid);
            prog_we   = 1'b1;
            prog_addr = IMEM_DEPTH_LOG2'((RESET_PC >> 2) + i);
            prog_data = stim[1 + i];
        end
        @(posedge clk);
        #1;
        prog_we = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst         = 1'b0;
        cycle_limit = 2 * prog_words + 20;
        running     = 1'b1;

        // Records are rd/value pairs, a zero rd closes the list
        rec_idx = 1 + prog_words;
        while (stim[rec_idx] !== 32'd0) begin
            if (rec_idx + 1 >= STIM_DEPTH) begin
                $display("Retire record list runs past the end of the stimulus array");
                $display("Simulation finished: FAIL");
                $fatal(1, "bad stimulus");
            end
            wait_for_retire();
            check_equal($sformatf("retire %0d rd", rec_num), stim[rec_idx], retire_rd);
            check_equal($sformatf("retire %0d data", rec_num), stim[rec_idx + 1], retire_data);
            rec_idx += 2;
            rec_num++;
        end
        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

/* verilog/alu.sv */
`timescale 1ns/1ps

module alu (
    input  rv_pkg::alu_op_t op,
    input  rv_pkg::xlen_t   a,
    input  rv_pkg::xlen_t   b,
    output rv_pkg::xlen_t   result
);
    import rv_pkg::*;

    logic [4:0] shamt;

    assign shamt = b[4:0];

    always_comb begin
        case (op)
            ALU_ADD: begin
                result = a + b;
            end
            ALU_SUB: begin
                result = a - b;
            end
            ALU_SLL: begin
                result = a << shamt;
            end
            ALU_SLT: begin
                result = {31'd0, $signed(a) < $signed(b)};
            end
            ALU_SLTU: begin
                result = {31'd0, a < b};
            end
            ALU_XOR: begin
                result = a ^ b;
            end
            ALU_SRL: begin
                result = a >> shamt;
            end
            ALU_SRA: begin
                result = $signed(a) >>> shamt;
            end
            ALU_OR: begin
                result = a | b;
            end
            ALU_AND: begin
                result = a & b;
            end
            // LUI passes the upper immediate straight through
            ALU_COPY_B: begin
                result = b;
            end
            default: begin
                result = '0;
            end
        endcase
    end

endmodule

/* verilog/data_mem.sv */
`timescale 1ns/1ps

module data_mem #(
    parameter int DEPTH_LOG2 = 10
) (
    input  logic                  clk,
    input  logic                  en,
    input  logic                  we,
    input  logic [DEPTH_LOG2-1:0] addr,
    input  rv_pkg::xlen_t         wdata,
    output rv_pkg::xlen_t         rdata
);
    import rv_pkg::*;

    xlen_t mem [2**DEPTH_LOG2];

    // Single port, full words only
    always_ff @(posedge clk) begin
        if (en) begin
            if (we) begin
                mem[addr] <= wdata;
            end
            rdata <= mem[addr];
        end
    end

endmodule

/* verilog/execute_stage.sv */
`timescale 1ns/1ps

module execute_stage #(
    parameter int DMEM_DEPTH_LOG2 = 10
) (
    input  logic                       clk,
    input  logic                       rst,
    input  rv_pkg::xlen_t              f_instr,
    input  rv_pkg::xlen_t              f_pc,
    output rv_pkg::reg_addr_t          rf_raddr1,
    output rv_pkg::reg_addr_t          rf_raddr2,
    input  rv_pkg::xlen_t              rf_rdata1,
    input  rv_pkg::xlen_t              rf_rdata2,
    input  rv_pkg::xlen_t              w_result,
    output logic                       x_redirect,
    output rv_pkg::xlen_t              x_target,
    output rv_pkg::xlen_t              w_instr,
    output rv_pkg::xlen_t              w_pc,
    output rv_pkg::xlen_t              w_alu,
    output logic [DMEM_DEPTH_LOG2-1:0] dmem_addr,
    output rv_pkg::xlen_t              dmem_wdata,
    output logic                       dmem_we,
    output logic                       dmem_en
);
    import rv_pkg::*;

    xlen_t      x_instr;
    xlen_t      x_pc;
    xlen_t      x_rs1;
    xlen_t      x_rs2;
    xlen_t      rs1_val;
    xlen_t      rs2_val;
    xlen_t      imm;
    xlen_t      alu_a;
    xlen_t      alu_b;
    xlen_t      alu_y;
    logic [6:0] opcode;
    logic [2:0] funct3;
    reg_addr_t  w_rd;
    logic       w_fwd_ok;
    logic       br_taken;
    alu_op_t    alu_op;

    // funct7[5] selects SUB only for register ops, SRA for both forms
    function automatic alu_op_t arith_op(input logic [2:0] f3, input logic alt,
                                         input logic is_reg);
        case (f3)
            F3_ADD_SUB: return (alt && is_reg) ? ALU_SUB : ALU_ADD;
            F3_SLL:     return ALU_SLL;
            F3_SLT:     return ALU_SLT;
            F3_SLTU:    return ALU_SLTU;
            F3_XOR:     return ALU_XOR;
            F3_SRL_SRA: return alt ? ALU_SRA : ALU_SRL;
            F3_OR:      return ALU_OR;
            F3_AND:     return ALU_AND;
            default:    return ALU_ADD;
        endcase
    endfunction

    assign rf_raddr1 = f_instr[19:15];
    assign rf_raddr2 = f_instr[24:20];

    // Writeback destination, valid for forwarding only when it is not x0
    assign w_rd     = w_instr[11:7];
    assign w_fwd_ok = writes_rd(w_instr) && (w_rd != '0);

    always_ff @(posedge clk) begin
        if (rst) begin
            x_instr <= NOP_INSTR;
        end else begin
            x_instr <= f_instr;
        end
    end

    // Register read, the write landing at this edge is bypassed in
    always_ff @(posedge clk) begin
        x_pc  <= f_pc;
        x_rs1 <= (w_fwd_ok && w_rd == rf_raddr1) ? w_result : rf_rdata1;
        x_rs2 <= (w_fwd_ok && w_rd == rf_raddr2) ? w_result : rf_rdata2;
    end

    assign opcode = x_instr[6:0];
    assign funct3 = x_instr[14:12];

    // Result of the instruction directly ahead
    assign rs1_val = (w_fwd_ok && w_rd == x_instr[19:15]) ? w_result : x_rs1;
    assign rs2_val = (w_fwd_ok && w_rd == x_instr[24:20]) ? w_result : x_rs2;

    always_comb begin
        case (opcode)
            OPC_OP_IMM, OPC_LOAD, OPC_JALR: begin
                imm = {{20{x_instr[31]}}, x_instr[31:20]};
            end
            OPC_STORE: begin
                imm = {{20{x_instr[31]}}, x_instr[31:25], x_instr[11:7]};
            end
            OPC_BRANCH: begin
                imm = {{19{x_instr[31]}}, x_instr[31], x_instr[7],
                       x_instr[30:25], x_instr[11:8], 1'b0};
            end
            OPC_LUI, OPC_AUIPC: begin
                imm = {x_instr[31:12], 12'd0};
            end
            default: begin
                imm = '0;
            end
        endcase
    end

    // Operand and operation select
    always_comb begin
        alu_op = ALU_ADD;
        alu_a  = rs1_val;
        alu_b  = imm;
        case (opcode)
            OPC_OP: begin
                alu_b  = rs2_val;
                alu_op = arith_op(funct3, x_instr[30], 1'b1);
            end
            OPC_OP_IMM: begin
                alu_op = arith_op(funct3, x_instr[30], 1'b0);
            end
            OPC_LUI: begin
                alu_op = ALU_COPY_B;
            end
            OPC_AUIPC: begin
                alu_a = x_pc;
            end
            default: begin
                alu_op = ALU_ADD;
            end
        endcase
    end

    alu u_alu (
        .op     (alu_op),
        .a      (alu_a),
        .b      (alu_b),
        .result (alu_y)
    );

    always_comb begin
        case (funct3)
            F3_BEQ:  br_taken = (rs1_val == rs2_val);
            F3_BNE:  br_taken = (rs1_val != rs2_val);
            F3_BLT:  br_taken = ($signed(rs1_val) < $signed(rs2_val));
            F3_BGE:  br_taken = ($signed(rs1_val) >= $signed(rs2_val));
            F3_BLTU: br_taken = (rs1_val < rs2_val);
            F3_BGEU: br_taken = (rs1_val >= rs2_val);
            default: br_taken = 1'b0;
        endcase
    end

    // Not-taken is the static guess, so only taken branches redirect
    assign x_redirect = ((opcode == OPC_BRANCH) && br_taken) || (opcode == OPC_JALR);
    assign x_target   = (opcode == OPC_JALR) ? {alu_y[31:1], 1'b0} : x_pc + imm;

    // Word access only
    assign dmem_en    = (opcode == OPC_LOAD) || (opcode == OPC_STORE);
    assign dmem_we    = (opcode == OPC_STORE);
    assign dmem_addr  = alu_y[DMEM_DEPTH_LOG2+1:2];
    assign dmem_wdata = rs2_val;

    always_ff @(posedge clk) begin
        if (rst) begin
            w_instr <= NOP_INSTR;
        end else begin
            w_instr <= x_instr;
        end
    end

    always_ff @(posedge clk) begin
        w_pc  <= x_pc;
        w_alu <= alu_y;
    end

endmodule

/* verilog/fetch_stage.sv */
`timescale 1ns/1ps

module fetch_stage #(
    parameter rv_pkg::xlen_t RESET_PC        = 32'h0000_0000,
    parameter int            IMEM_DEPTH_LOG2 = 10
) (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       x_redirect,
    input  rv_pkg::xlen_t              x_target,
    output logic [IMEM_DEPTH_LOG2-1:0] imem_addr,
    input  rv_pkg::xlen_t              imem_rdata,
    output rv_pkg::xlen_t              f_instr,
    output rv_pkg::xlen_t              f_pc
);
    import rv_pkg::*;

    xlen_t pc_q;
    xlen_t next_pc;
    xlen_t jal_imm;
    logic  kill;
    logic  is_jal;

    // The word arriving now is the wrong-path successor of a redirecting op
    assign kill    = x_redirect;
    assign f_instr = kill ? NOP_INSTR : imem_rdata;
    assign f_pc    = pc_q;

    assign is_jal  = (f_instr[6:0] == OPC_JAL);
    assign jal_imm = {{12{f_instr[31]}}, f_instr[19:12], f_instr[20],
                      f_instr[30:21], 1'b0};

    // Next PC, highest priority first
    always_comb begin
        if (rst) begin
            next_pc = RESET_PC;
        end else if (x_redirect) begin
            next_pc = x_target;
        end else if (is_jal) begin
            next_pc = pc_q + jal_imm;
        end else begin
            next_pc = pc_q + 32'd4;
        end
    end

    // pc_q always tracks the address of the word now leaving the RAM
    always_ff @(posedge clk) begin
        if (rst) begin
            pc_q <= RESET_PC;
        end else begin
            pc_q <= next_pc;
        end
    end

    assign imem_addr = next_pc[IMEM_DEPTH_LOG2+1:2];

endmodule

/* verilog/inst_mem.sv */
`timescale 1ns/1ps

module inst_mem #(
    parameter int DEPTH_LOG2 = 10
) (
    input  logic                  clk,
    input  logic                  we,
    input  logic [DEPTH_LOG2-1:0] waddr,
    input  rv_pkg::xlen_t         wdata,
    input  logic [DEPTH_LOG2-1:0] raddr,
    output rv_pkg::xlen_t         rdata
);
    import rv_pkg::*;

    xlen_t mem [2**DEPTH_LOG2];

    // Program load port, only active while the core sits in reset
    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    // Fetch port, word appears one cycle after the address
    always_ff @(posedge clk) begin
        rdata <= mem[raddr];
    end

endmodule

/* verilog/reg_file.sv */
`timescale 1ns/1ps

module reg_file (
    input  logic              clk,
    input  logic              we,
    input  rv_pkg::reg_addr_t waddr,
    input  rv_pkg::xlen_t     wdata,
    input  rv_pkg::reg_addr_t raddr1,
    input  rv_pkg::reg_addr_t raddr2,
    output rv_pkg::xlen_t     rdata1,
    output rv_pkg::xlen_t     rdata2
);
    import rv_pkg::*;

    xlen_t regs [32];

    always_ff @(posedge clk) begin
        if (we && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

    // x0 is never written, so mask it on the read side
    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

/* verilog/rv_core_top.sv */
`timescale 1ns/1ps

module rv_core_top #(
    parameter rv_pkg::xlen_t RESET_PC        = 32'h0000_0000,
    parameter int            IMEM_DEPTH_LOG2 = 10,
    parameter int            DMEM_DEPTH_LOG2 = 10
) (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       prog_we,
    input  logic [IMEM_DEPTH_LOG2-1:0] prog_addr,
    input  rv_pkg::xlen_t              prog_data,
    output logic                       retire_valid,
    output rv_pkg::reg_addr_t          retire_rd,
    output rv_pkg::xlen_t              retire_data
);
    import rv_pkg::*;

    logic [IMEM_DEPTH_LOG2-1:0] imem_addr;
    xlen_t                      imem_rdata;
    xlen_t                      f_instr;
    xlen_t                      f_pc;
    logic                       x_redirect;
    xlen_t                      x_target;
    reg_addr_t                  rf_raddr1;
    reg_addr_t                  rf_raddr2;
    xlen_t                      rf_rdata1;
    xlen_t                      rf_rdata2;
    xlen_t                      w_instr;
    xlen_t                      w_pc;
    xlen_t                      w_alu;
    xlen_t                      w_result;
    logic                       rf_we;
    reg_addr_t                  rf_waddr;
    logic [DMEM_DEPTH_LOG2-1:0] dmem_addr;
    xlen_t                      dmem_wdata;
    xlen_t                      dmem_rdata;
    logic                       dmem_we;
    logic                       dmem_en;

    inst_mem #(
        .DEPTH_LOG2 (IMEM_DEPTH_LOG2)
    ) u_imem (
        .clk   (clk),
        .we    (prog_we),
        .waddr (prog_addr),
        .wdata (prog_data),
        .raddr (imem_addr),
        .rdata (imem_rdata)
    );

    fetch_stage #(
        .RESET_PC        (RESET_PC),
        .IMEM_DEPTH_LOG2 (IMEM_DEPTH_LOG2)
    ) u_fetch (
        .clk        (clk),
        .rst        (rst),
        .x_redirect (x_redirect),
        .x_target   (x_target),
        .imem_addr  (imem_addr),
        .imem_rdata (imem_rdata),
        .f_instr    (f_instr),
        .f_pc       (f_pc)
    );

    reg_file u_rf (
        .clk    (clk),
        .we     (rf_we),
        .waddr  (rf_waddr),
        .wdata  (w_result),
        .raddr1 (rf_raddr1),
        .raddr2 (rf_raddr2),
        .rdata1 (rf_rdata1),
        .rdata2 (rf_rdata2)
    );

    execute_stage #(
        .DMEM_DEPTH_LOG2 (DMEM_DEPTH_LOG2)
    ) u_execute (
        .clk        (clk),
        .rst        (rst),
        .f_instr    (f_instr),
        .f_pc       (f_pc),
        .rf_raddr1  (rf_raddr1),
        .rf_raddr2  (rf_raddr2),
        .rf_rdata1  (rf_rdata1),
        .rf_rdata2  (rf_rdata2),
        .w_result   (w_result),
        .x_redirect (x_redirect),
        .x_target   (x_target),
        .w_instr    (w_instr),
        .w_pc       (w_pc),
        .w_alu      (w_alu),
        .dmem_addr  (dmem_addr),
        .dmem_wdata (dmem_wdata),
        .dmem_we    (dmem_we),
        .dmem_en    (dmem_en)
    );

    data_mem #(
        .DEPTH_LOG2 (DMEM_DEPTH_LOG2)
    ) u_dmem (
        .clk   (clk),
        .en    (dmem_en),
        .we    (dmem_we),
        .addr  (dmem_addr),
        .wdata (dmem_wdata),
        .rdata (dmem_rdata)
    );

    writeback_stage u_writeback (
        .w_instr    (w_instr),
        .w_pc       (w_pc),
        .w_alu      (w_alu),
        .dmem_rdata (dmem_rdata),
        .rf_we      (rf_we),
        .rf_waddr   (rf_waddr),
        .w_result   (w_result)
    );

    // Retire stream mirrors the register file write, x0 targets (no-ops) dropped
    assign retire_valid = rf_we && (rf_waddr != '0);
    assign retire_rd    = rf_waddr;
    assign retire_data  = w_result;

endmodule

/* verilog/rv_pkg.sv */
package rv_pkg;

    localparam int XLEN = 32;

    typedef logic [XLEN-1:0] xlen_t;
    typedef logic [4:0]      reg_addr_t;

    typedef enum logic [3:0] {
        ALU_ADD    = 4'd0,
        ALU_SUB    = 4'd1,
        ALU_SLL    = 4'd2,
        ALU_SLT    = 4'd3,
        ALU_SLTU   = 4'd4,
        ALU_XOR    = 4'd5,
        ALU_SRL    = 4'd6,
        ALU_SRA    = 4'd7,
        ALU_OR     = 4'd8,
        ALU_AND    = 4'd9,
        ALU_COPY_B = 4'd10
    } alu_op_t;

    // Major opcodes, bits [6:0]
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;

    // Branch conditions
    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    // Integer ALU operations, shared by OP and OP_IMM
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SRL_SRA = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    // addi x0, x0, 0
    localparam xlen_t NOP_INSTR = 32'h0000_0013;

    // True for every opcode that carries a destination register
    function automatic logic writes_rd(input xlen_t instr);
        logic [6:0] opc;
        opc = instr[6:0];
        return opc inside {OPC_OP, OPC_OP_IMM, OPC_LUI, OPC_AUIPC,
                           OPC_LOAD, OPC_JAL, OPC_JALR};
    endfunction

endpackage

/* verilog/writeback_stage.sv */
`timescale 1ns/1ps

module writeback_stage (
    input  rv_pkg::xlen_t     w_instr,
    input  rv_pkg::xlen_t     w_pc,
    input  rv_pkg::xlen_t     w_alu,
    input  rv_pkg::xlen_t     dmem_rdata,
    output logic              rf_we,
    output rv_pkg::reg_addr_t rf_waddr,
    output rv_pkg::xlen_t     w_result
);
    import rv_pkg::*;

    logic [6:0] opcode;

    assign opcode   = w_instr[6:0];
    assign rf_we    = writes_rd(w_instr);
    assign rf_waddr = w_instr[11:7];

    // Load data arrives from the RAM in this cycle
    always_comb begin
        case (opcode)
            OPC_LOAD: begin
                w_result = dmem_rdata;
            end
            OPC_JAL, OPC_JALR: begin
                w_result = w_pc + 32'd4;
            end
            default: begin
                w_result = w_alu;
            end
        endcase
    end

endmodule
